// File: eth_tx.f
+incdir+include
source/eth_tx_pkg.sv
source/eth_crc_if.sv
source/eth_crc32.sv
source/eth_tx_buffer.sv
source/eth_mii_tx.sv
source/eth_tx_top.sv
testbench/tb_eth_tx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the eth_tx testbench with Verilator.
set -u

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log
FAIL_MSG="Done: errors found"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f eth_tx.f --top-module tb_eth_tx -Mdir "$BUILD_DIR"
status=$?
if [ "$status" -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

"./$BUILD_DIR/Vtb_eth_tx" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qF "$FAIL_MSG" "$LOG"; then
   echo "simulation FAILED"
   exit 1
fi

echo "simulation PASSED"
exit 0

// File: testbench/tb_eth_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_cfg.svh"

module tb_eth_tx;

   localparam int AW  = `ETH_TX_ADDR_W;
   localparam int PRE = `ETH_TX_PRE_LEN;
   localparam int HDR = `ETH_TX_HDR_LEN;

   // wire cycles of all six frames, payloads 0, 46, 4, 10, 20 and 5
   localparam int WIRE_CYCLES = 2 * (6 * (PRE + HDR + 4) + 85);
   // buffer loads and idle gaps on top of that
   localparam int TIMEOUT_CYCLES = 3 * WIRE_CYCLES + 200;

   logic          TX_CLK;
   logic          rst;
   logic          wr_en;
   logic [AW-1:0] wr_addr;
   logic [7:0]    wr_data;
   logic          send_valid;
   logic [AW-1:0] send_nbytes;
   logic          send_ready;
   logic          TX_EN;
   logic [3:0]    TX_DATA;

   logic [7:0]    image [];
   int            cyc = 0;
   int            value_errors = 0;
   int            other_errors = 0;
   int            accept_cyc [$];
   int            rise_cyc [$];
   int            fall_cyc [$];
   int            frame_start [$];
   logic [3:0]    nibs [$];
   logic          tx_en_d = 1'b0;

   eth_tx_top u_dut (
      .TX_CLK      (TX_CLK),
      .rst         (rst),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .send_valid  (send_valid),
      .send_nbytes (send_nbytes),
      .send_ready  (send_ready),
      .TX_EN       (TX_EN),
      .TX_DATA     (TX_DATA)
   );

   initial begin
      TX_CLK = 1'b0;
      forever #50 TX_CLK = ~TX_CLK;
   end

   // handshake seen with the values from before the edge
   always @(posedge TX_CLK) begin
      if (send_valid && send_ready) begin
         accept_cyc.push_back(cyc);
      end
      cyc = cyc + 1;
      if (cyc > TIMEOUT_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("errors: %0d wrong values, %0d other", value_errors, other_errors);
         $display("Done: errors found");
         $finish;
      end
   end

   // MII capture, mid-cycle
   always @(negedge TX_CLK) begin
      if (TX_EN === 1'b1) begin
         if (!tx_en_d) begin
            rise_cyc.push_back(cyc);
            frame_start.push_back(nibs.size());
         end
         nibs.push_back(TX_DATA);
         assert (send_ready == 1'b0) else note_error("send_ready is high while TX_EN is high");
      end else if (tx_en_d) begin
         fall_cyc.push_back(cyc);
         assert (send_ready == 1'b1) else note_error("send_ready did not rise when TX_EN fell");
      end
      tx_en_d = (TX_EN === 1'b1);
   end

   task automatic note_error(input string what);
      other_errors++;
      $display("ERROR at %0t: %s", $time, what);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual == expected) else begin
         value_errors++;
         $display("FAIL at %0t: %s expected %0h got %0h", $time, name, expected, actual);
      end
   endtask

   // bit-serial shift register, normal polynomial, bits in wire order
   function automatic logic [31:0] model_fcs(input logic [7:0] bytes [$]);
      logic [31:0] lfsr;
      logic [31:0] fcs;
      logic [7:0]  data;
      logic        fb;
      lfsr = 32'hFFFF_FFFF;
      foreach (bytes[a]) begin
         data = bytes[a];
         for (int b = 0; b < 8; b++) begin
            fb   = lfsr[31] ^ data[0];
            lfsr = {lfsr[30:0], 1'b0};
            if (fb) begin
               lfsr = lfsr ^ 32'h04C1_1DB7;
            end
            data = data >> 1;
         end
      end
      // complement goes out msb first, so bit 31 becomes wire bit 0
      lfsr = ~lfsr;
      fcs  = {<<{lfsr}};
      return fcs;
   endfunction

   task automatic write_preamble();
      for (int a = 0; a < PRE - 1; a++) begin
         image[a] = 8'h55;
      end
      image[PRE - 1] = 8'hD5;
   endtask

   task automatic fill_image(input int nbytes);
      write_preamble();
      for (int a = PRE; a < PRE + HDR + nbytes; a++) begin
         image[a] = 8'($urandom);
      end
   endtask

   task automatic load_buffer(input int nbytes);
      for (int a = 0; a < PRE + HDR + nbytes; a++) begin
         @(negedge TX_CLK);
         wr_en   = 1'b1;
         wr_addr = AW'(a);
         wr_data = image[a];
      end
      @(negedge TX_CLK);
      wr_en = 1'b0;
   endtask

   // holds send_valid until the DUT takes the request
   task automatic request_send(input int nbytes);
      int seen;
      seen = accept_cyc.size();
      @(negedge TX_CLK);
      send_valid  = 1'b1;
      send_nbytes = AW'(nbytes);
      while (accept_cyc.size() == seen) begin
         @(negedge TX_CLK);
      end
      send_valid = 1'b0;
   endtask

   task automatic wait_frames(input int count);
      while (fall_cyc.size() < count) begin
         @(negedge TX_CLK);
      end
   endtask

   task automatic check_frame(input int idx, input int nbytes);
      int          last;
      int          k;
      logic [31:0] fcs;
      logic [7:0]  body [$];
      last = PRE + HDR + nbytes - 1;
      // second rising edge after acceptance, seen on the falling edge after it
      check_value("TX_EN delay", 32'd3, 32'(rise_cyc[idx] - accept_cyc[idx]));
      check_value("TX_EN length", 32'(2 * (last + 5)), 32'(fall_cyc[idx] - rise_cyc[idx]));
      if (fall_cyc[idx] - rise_cyc[idx] == 2 * (last + 5)) begin
         k = frame_start[idx];
         for (int a = 0; a <= last; a++) begin
            check_value("TX_DATA", 32'(image[a][3:0]), 32'(nibs[k]));
            check_value("TX_DATA", 32'(image[a][7:4]), 32'(nibs[k + 1]));
            k = k + 2;
            if (a >= PRE) begin
               body.push_back(image[a]);
            end
         end
         fcs = model_fcs(body);
         for (int i = 0; i < 8; i++) begin
            check_value("TX_DATA fcs", 32'(fcs[3:0]), 32'(nibs[k + i]));
            fcs = fcs >> 4;
         end
      end
   endtask

   task automatic check_reset();
      repeat (8) @(negedge TX_CLK);
      check_value("TX_EN", 32'd0, 32'(TX_EN));
      check_value("send_ready", 32'd1, 32'(send_ready));
      rst = 1'b0;
      repeat (2) @(negedge TX_CLK);
      check_value("TX_EN", 32'd0, 32'(TX_EN));
      check_value("send_ready", 32'd1, 32'(send_ready));
   endtask

   task automatic min_frame();
      int idx;
      idx = fall_cyc.size();
      fill_image(0);
      load_buffer(0);
      request_send(0);
      wait_frames(idx + 1);
      check_frame(idx, 0);
   endtask

   task automatic random_payload();
      int idx;
      idx = fall_cyc.size();
      fill_image(46);
      load_buffer(46);
      request_send(46);
      wait_frames(idx + 1);
      check_frame(idx, 46);
   endtask

   task automatic known_answer();
      string      digits;
      logic [7:0] check_bytes [$];
      int         idx;
      digits = "123456789";
      for (int i = 0; i < digits.len(); i++) begin
         check_bytes.push_back(digits[i]);
      end
      // standard CRC-32 check value
      check_value("model_fcs", 32'hCBF4_3926, model_fcs(check_bytes));
      write_preamble();
      // header and payload are the string twice
      for (int a = 0; a < HDR + 4; a++) begin
         image[PRE + a] = digits[a % 9];
      end
      load_buffer(4);
      idx = fall_cyc.size();
      request_send(4);
      wait_frames(idx + 1);
      check_frame(idx, 4);
   endtask

   task automatic back_to_back();
      int idx;
      idx = fall_cyc.size();
      fill_image(20);
      load_buffer(20);
      request_send(10);
      // held through the first frame
      request_send(20);
      wait_frames(idx + 2);
      check_frame(idx, 10);
      check_frame(idx + 1, 20);
      assert (accept_cyc[idx + 1] >= fall_cyc[idx])
         else note_error("second request was accepted before the first frame ended");
   endtask

   task automatic length_capture();
      int idx;
      idx = fall_cyc.size();
      fill_image(5);
      load_buffer(5);
      request_send(5);
      send_nbytes = AW'(40);
      wait_frames(idx + 1);
      check_frame(idx, 5);
   endtask

   initial begin
      void'($urandom(32'he0d7_386f));
      image       = new[2 ** AW];
      rst         = 1'b1;
      wr_en       = 1'b0;
      wr_addr     = '0;
      wr_data     = '0;
      send_valid  = 1'b0;
      send_nbytes = '0;

      check_reset();
      min_frame();
      random_payload();
      known_answer();
      back_to_back();
      length_capture();
      repeat (4) @(negedge TX_CLK);

      $display("errors: %0d wrong values, %0d other", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: source/eth_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_cfg.svh"

module eth_tx_top (
   input  logic                      TX_CLK,
   input  logic                      rst,
   input  logic                      wr_en,
   input  logic [`ETH_TX_ADDR_W-1:0] wr_addr,
   input  logic [7:0]                wr_data,
   input  logic                      send_valid,
   input  logic [`ETH_TX_ADDR_W-1:0] send_nbytes,
   output logic                      send_ready,
   output logic                      TX_EN,
   output logic [3:0]                TX_DATA
);

   logic [`ETH_TX_ADDR_W-1:0] rd_addr;
   logic [7:0]                rd_data;

   eth_crc_if crc_bus ();

   eth_tx_buffer u_buffer (
      .TX_CLK  (TX_CLK),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   eth_mii_tx u_mii_tx (
      .TX_CLK      (TX_CLK),
      .rst         (rst),
      .send_valid  (send_valid),
      .send_nbytes (send_nbytes),
      .send_ready  (send_ready),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .crc         (crc_bus.engine),
      .TX_EN       (TX_EN),
      .TX_DATA     (TX_DATA)
   );

   eth_crc32 u_crc (
      .TX_CLK (TX_CLK),
      .rst    (rst),
      .crc    (crc_bus.crc)
   );

endmodule

`default_nettype wire

// File: source/eth_mii_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_cfg.svh"

module eth_mii_tx (
   input  logic                      TX_CLK,
   input  logic                      rst,
   input  logic                      send_valid,
   input  logic [`ETH_TX_ADDR_W-1:0] send_nbytes,
   output logic                      send_ready,
   output logic [`ETH_TX_ADDR_W-1:0] rd_addr,
   input  logic [7:0]                rd_data,
   eth_crc_if.engine                 crc,
   output logic                      TX_EN,
   output logic [3:0]                TX_DATA
);

   localparam int unsigned AW = `ETH_TX_ADDR_W;
   localparam logic [AW-1:0] PRE_LEN = AW'(`ETH_TX_PRE_LEN);
   localparam logic [AW-1:0] BODY_START = AW'(`ETH_TX_PRE_LEN + `ETH_TX_HDR_LEN);

   typedef enum logic [2:0] {
      S_IDLE,
      S_FETCH,
      S_LO,
      S_HI,
      S_FCS
   } state_e;

   state_e        state;
   logic          rst_meta;
   logic          tx_rst;
   logic          accept;
   logic          crc_start;
   logic [2:0]    nib;
   logic [AW-1:0] nbytes_q;
   logic [AW-1:0] end_addr;

   // reset sync, assert async, release after two edges
   always_ff @(posedge TX_CLK or posedge rst) begin
      if (rst) begin
         rst_meta <= 1'b1;
         tx_rst   <= 1'b1;
      end else begin
         rst_meta <= 1'b0;
         tx_rst   <= rst_meta;
      end
   end

   assign accept = send_valid && send_ready;

   // rd_addr runs one ahead in the high nibble, so this matches the last byte
   assign end_addr = BODY_START + nbytes_q;

   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         state      <= S_IDLE;
         send_ready <= 1'b1;
         TX_EN      <= 1'b0;
         rd_addr    <= '0;
         nib        <= '0;
         crc_start  <= 1'b0;
      end else begin
         crc_start <= 1'b0;
         case (state)
            S_IDLE: begin
               TX_EN      <= 1'b0;
               send_ready <= 1'b1;
               if (accept) begin
                  send_ready <= 1'b0;
                  crc_start  <= 1'b1;
                  state      <= S_FETCH;
               end
            end
            // byte 0 read in flight
            S_FETCH: state <= S_LO;
            S_LO: begin
               TX_EN   <= 1'b1;
               rd_addr <= rd_addr + 1'b1;
               state   <= S_HI;
            end
            S_HI: begin
               if (rd_addr == end_addr) begin
                  rd_addr <= '0;
                  nib     <= '0;
                  state   <= S_FCS;
               end else begin
                  state <= S_LO;
               end
            end
            S_FCS: begin
               nib <= nib + 1'b1;
               if (nib == 3'd7) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // nibble mux and captured length
   always_ff @(posedge TX_CLK) begin
      if (accept) begin
         nbytes_q <= send_nbytes;
      end
      case (state)
         S_LO:    TX_DATA <= rd_data[3:0];
         S_HI:    TX_DATA <= rd_data[7:4];
         S_FCS:   TX_DATA <= nib[0] ? crc.fcs.bytes[nib[2:1]][7:4]
                                    : crc.fcs.bytes[nib[2:1]][3:0];
         default: TX_DATA <= 4'h0;
      endcase
   end

   assign crc.start   = crc_start;
   assign crc.data    = rd_data;
   // header and payload only, one fold per byte
   assign crc.data_en = (state == S_HI) && (rd_addr > PRE_LEN);

   a_ready_not_during_frame : assert property (
      @(posedge TX_CLK) disable iff (tx_rst)
      !(TX_EN && send_ready)
   );

   a_crc_only_on_wire : assert property (
      @(posedge TX_CLK) disable iff (tx_rst)
      crc.data_en |-> TX_EN
   );

endmodule

`default_nettype wire

// File: source/eth_tx_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_cfg.svh"

module eth_tx_buffer (
   input  logic                      TX_CLK,
   input  logic                      wr_en,
   input  logic [`ETH_TX_ADDR_W-1:0] wr_addr,
   input  logic [7:0]                wr_data,
   input  logic [`ETH_TX_ADDR_W-1:0] rd_addr,
   output logic [7:0]                rd_data
);

   localparam int unsigned DEPTH = 2 ** `ETH_TX_ADDR_W;

   logic [7:0] mem [DEPTH];

   // host side, assembled while the sequencer is idle
   always_ff @(posedge TX_CLK) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // one cycle read latency
   always_ff @(posedge TX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// File: source/eth_crc32.sv
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
   input  logic  TX_CLK,
   input  logic  rst,
   eth_crc_if.crc crc
);

   logic [31:0] remainder;
   logic [31:0] next_rem;

   // eight shift steps of the reflected CRC, one byte per clock
   always_comb begin
      next_rem = remainder ^ {24'h0, crc.data};
      for (int i = 0; i < 8; i++) begin
         if (next_rem[0]) begin
            next_rem = (next_rem >> 1) ^ eth_tx_pkg::CRC_POLY_REFL;
         end else begin
            next_rem = next_rem >> 1;
         end
      end
   end

   always_ff @(posedge TX_CLK or posedge rst) begin
      if (rst) begin
         remainder <= eth_tx_pkg::CRC_INIT;
      end else if (crc.start) begin
         remainder <= eth_tx_pkg::CRC_INIT;
      end else if (crc.data_en) begin
         remainder <= next_rem;
      end
   end

   // reflected form already puts byte 0 in the low bits
   assign crc.fcs.word = ~remainder;

   // the engine never restarts a frame while it is still feeding bytes
   a_start_not_with_data : assert property (
      @(posedge TX_CLK) disable iff (rst)
      !(crc.start && crc.data_en)
   );

endmodule

`default_nettype wire

// File: source/eth_crc_if.sv
`timescale 1ns/1ps
`default_nettype none

interface eth_crc_if;

   logic                   start;
   logic [7:0]             data;
   logic                   data_en;
   eth_tx_pkg::fcs_word_u  fcs;

   modport engine (
      output start,
      output data,
      output data_en,
      input  fcs
   );

   modport crc (
      input  start,
      input  data,
      input  data_en,
      output fcs
   );

endinterface

`default_nettype wire

// File: source/eth_tx_pkg.sv
`default_nettype none

package eth_tx_pkg;

   // frame check sequence as the CRC block hands it over,
   // or split into bytes in the order they go on the wire
   typedef union packed {
      logic [31:0]      word;
      logic [3:0][7:0]  bytes;
   } fcs_word_u;

   // 0x04C11DB7 with the bit order reversed
   localparam logic [31:0] CRC_POLY_REFL = 32'hEDB8_8320;

   localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// File: include/eth_tx_cfg.svh
`ifndef ETH_TX_CFG_SVH
`define ETH_TX_CFG_SVH

// byte address into the frame buffer, 2048 bytes
`define ETH_TX_ADDR_W 11

// preamble plus start-of-frame delimiter
`define ETH_TX_PRE_LEN 8

// destination, source and ethertype
`define ETH_TX_HDR_LEN 14

`endif
